// ==== flist.f ====
+incdir+verif
src/fft8_pkg.sv
src/fft8_load.sv
src/fft8_butterfly.sv
src/fft8_stage.sv
src/fft8_top.sv
verif/fft8_asserts.sv
verif/fft8_tb.sv

// ==== sim.sh ====
#!/bin/sh
# build and run the FFT testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fft8_tb -f flist.f -o fft8_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/fft8_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== verif/fft8_ref.svh ====
//////////////////////////////////////////////////
// reference model, 0.707 scaling, butterfly and
// the full 8-point transform in 16-bit wrap
//////////////////////////////////////////////////

`ifndef FFT8_REF_SVH
`define FFT8_REF_SVH

// shifts summed in int, wrapped once at the end
function automatic sample_t ref_scale(input sample_t x);
  int acc;
  acc = 0;
  for (int i = 0; i < N_SCALE; i++)
  begin
    acc = acc + (int'(x) >>> SCALE_SHIFTS[i]);  // floor division by 2^n
  end
  return sample_t'(acc);
endfunction

// b rotated by W8^p, then a plus and minus the rotated b
function automatic void ref_butterfly(input sample_t ar, input sample_t ai,
                                      input sample_t br, input sample_t bi, input int p,
                                      output sample_t x0r, output sample_t x0i,
                                      output sample_t x1r, output sample_t x1i);
  sample_t r;
  sample_t d;
  sample_t wr;
  sample_t wi;
  r  = br + bi;
  d  = bi - br;
  wr = br;
  wi = bi;
  if (p == 1)
  begin
    wr = ref_scale(r);
    wi = ref_scale(d);
  end
  else if (p == 2)
  begin
    wr = bi;
    wi = -br;
  end
  else if (p == 3)
  begin
    wr = ref_scale(d);
    wi = -ref_scale(r);
  end
  x0r = ar + wr;
  x0i = ai + wi;
  x1r = ar - wr;
  x1i = ai - wi;
endfunction

// iterative decimation in time, natural order out
function automatic void ref_fft8(input sample_vec_t xr, input sample_vec_t xi,
                                 output sample_vec_t yr, output sample_vec_t yi);
  int rev;
  int lo;
  int hi;
  sample_t t0r;
  sample_t t0i;
  sample_t t1r;
  sample_t t1i;
  for (int n = 0; n < N_POINTS; n++)
  begin
    rev   = ((n & 1) << 2) | (n & 2) | ((n >> 2) & 1);  // 3-bit reversal
    yr[n] = xr[rev];
    yi[n] = xi[rev];
  end
  for (int half = 1; half < N_POINTS; half = half * 2)
  begin
    for (int base = 0; base < N_POINTS; base += 2 * half)
    begin
      for (int j = 0; j < half; j++)
      begin
        lo = base + j;
        hi = lo + half;
        ref_butterfly(yr[lo], yi[lo], yr[hi], yi[hi], j * (N_POINTS / 2 / half),
                      t0r, t0i, t1r, t1i);
        yr[lo] = t0r;
        yi[lo] = t0i;
        yr[hi] = t1r;
        yi[hi] = t1i;
      end
    end
  end
endfunction

`endif

// ==== verif/fft8_tb.sv ====
//////////////////////////////////////////////////
// testbench for the 8-point FFT, stimulus,
// comparator, watchdog and summary
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_tb
  import fft8_pkg::*;
;

  localparam int CLK_PERIOD  = 40;
  localparam int N_RANDOM    = 24;
  localparam int DRAIN_MAX   = 20;  // cycles allowed for one result
  localparam int TEST_CYCLES = 4 + 2 * 12 + N_RANDOM * 8 + 20 + 12;
  localparam int MARGIN      = 100;

  logic        clk;
  logic        reset_n;
  logic        write;
  logic        start_fft;
  sample_vec_t in_real;
  sample_vec_t in_imag;
  sample_vec_t out_real;
  sample_vec_t out_imag;
  logic        fft_ready;

  sample_vec_t hold_real;       // model of the captured block
  sample_vec_t hold_imag;
  sample_vec_t last_exp_real;   // transform of the last launched block
  sample_vec_t last_exp_imag;
  sample_vec_t exp_real_q [$];  // one entry per start
  sample_vec_t exp_imag_q [$];
  logic [3:0]  start_hist;      // start_fft at the last four negedges
  logic [31:0] lcg_state = 32'd34911;
  int          n_errors  = 0;
  int          n_checks  = 0;
  int          n_tests   = 0;
  int          n_failed  = 0;
  int          test_base = 0;

  `include "fft8_ref.svh"

  fft8_top u_fft8_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .write     (write),
    .start_fft (start_fft),
    .in_real   (in_real),
    .in_imag   (in_imag),
    .out_real  (out_real),
    .out_imag  (out_imag),
    .fft_ready (fft_ready)
  );

  bind fft8_top fft8_asserts u_asserts (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_fft    (start_fft),
    .launch_valid (launch_valid),
    .fft_ready    (fft_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", TEST_CYCLES + MARGIN);
    $display("TEST FAILED");
    $finish;
  end

  function automatic sample_t lcg_sample();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return sample_t'(lcg_state[31:16]);  // upper bits are the better ones
  endfunction

  task automatic random_block(output sample_vec_t re, output sample_vec_t im);
    for (int k = 0; k < N_POINTS; k++)
    begin
      re[k] = lcg_sample();
      im[k] = lcg_sample();
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("MISMATCH %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("MISMATCH fft_ready got %h exp %h", got, exp);
    end
  endtask

  task automatic check_block(input string tag, input sample_vec_t er, input sample_vec_t ei);
    for (int k = 0; k < N_POINTS; k++)
    begin
      check_sample($sformatf("%s out_real[%0d]", tag, k), out_real[k], er[k]);
      check_sample($sformatf("%s out_imag[%0d]", tag, k), out_imag[k], ei[k]);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  // a start launches the block held before this edge
  task automatic drive(input logic wr, input logic st, input sample_vec_t re,
                       input sample_vec_t im);
    sample_vec_t er;
    sample_vec_t ei;
    @(posedge clk);
    write     <= wr;
    start_fft <= st;
    in_real   <= re;
    in_imag   <= im;
    if (st)
    begin
      ref_fft8(hold_real, hold_imag, er, ei);
      exp_real_q.push_back(er);
      exp_imag_q.push_back(ei);
      last_exp_real = er;
      last_exp_imag = ei;
    end
    if (wr)
    begin
      hold_real = re;
      hold_imag = im;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 1'b0, '0, '0);
  endtask

  task automatic launch_block(input sample_vec_t re, input sample_vec_t im);
    drive(1'b1, 1'b0, re, im);
    drive(1'b0, 1'b1, '0, '0);
    idle(1);  // this edge samples the start
  endtask

  // lat counts edges after the start edge
  task automatic wait_ready(output int lat);
    lat = 0;
    @(negedge clk);
    while (!fft_ready && lat < DRAIN_MAX)
    begin
      @(negedge clk);
      lat++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_real_q.size() != 0 && n < DRAIN_MAX)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_real_q.size() != 0)
    begin
      n_errors++;
      $display("%0d expected results never arrived", exp_real_q.size());
      exp_real_q.delete();
      exp_imag_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = n_errors - test_base;
    n_tests++;
    if (errs != 0)
      n_failed++;
    $display("test %0d %s: %s, %0d errors", n_tests, name, (errs == 0) ? "pass" : "FAIL", errs);
    test_base = n_errors;
  endtask

  //////////////////////////////////////////////////
  // comparator, stable values at the falling edge
  //////////////////////////////////////////////////
  always @(negedge clk)
  begin : compare
    sample_vec_t er;
    sample_vec_t ei;
    if (!reset_n)
      start_hist = '0;
    else
    begin
      check_ready(fft_ready, start_hist[3]);
      if (fft_ready && exp_real_q.size() == 0)
      begin
        n_errors++;
        $display("fft_ready pulsed with no block in flight");
      end
      else if (fft_ready)
      begin
        er = exp_real_q.pop_front();
        ei = exp_imag_q.pop_front();
        check_block("result", er, ei);
      end
      start_hist = {start_hist[2:0], start_fft};
    end
  end

  initial
  begin
    sample_vec_t br;
    sample_vec_t bi;
    int          lat;
    reset_n       = 1'b0;
    write         = 1'b0;
    start_fft     = 1'b0;
    in_real       = '0;
    in_imag       = '0;
    hold_real     = '0;
    hold_imag     = '0;
    last_exp_real = '0;
    last_exp_imag = '0;
    start_hist    = '0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    @(negedge clk);
    check_ready(fft_ready, 1'b0);
    check_block("reset", '0, '0);
    end_test("reset state");

    // impulse, every bin equals x0
    br    = '0;
    bi    = '0;
    br[0] = 16'sh3a5c;
    bi[0] = -16'sd1200;
    launch_block(br, bi);
    wait_ready(lat);
    if (lat != 3)
    begin
      n_errors++;
      $display("fft_ready came %0d cycles after start instead of 3", lat);
    end
    for (int k = 0; k < N_POINTS; k++)
    begin
      check_sample($sformatf("impulse out_real[%0d]", k), out_real[k], br[0]);
      check_sample($sformatf("impulse out_imag[%0d]", k), out_imag[k], bi[0]);
    end
    wait_drain();
    end_test("impulse");

    // dc, X0 = 8c wrapped and the rest zero
    for (int k = 0; k < N_POINTS; k++)
    begin
      br[k] = 16'sh1234;
      bi[k] = -16'sh0456;
    end
    launch_block(br, bi);
    wait_ready(lat);
    check_sample("dc out_real[0]", out_real[0], sample_t'(br[0] * 16'sd8));
    check_sample("dc out_imag[0]", out_imag[0], sample_t'(bi[0] * 16'sd8));
    for (int k = 1; k < N_POINTS; k++)
    begin
      check_sample($sformatf("dc out_real[%0d]", k), out_real[k], 16'sd0);
      check_sample($sformatf("dc out_imag[%0d]", k), out_imag[k], 16'sd0);
    end
    wait_drain();
    end_test("dc");

    for (int b = 0; b < N_RANDOM; b++)
    begin
      random_block(br, bi);
      launch_block(br, bi);
      wait_drain();
    end
    end_test("random blocks");

    // starts in consecutive cycles, write and start overlap
    for (int b = 0; b < N_POINTS; b++)
    begin
      random_block(br, bi);
      drive(1'b1, b != 0, br, bi);
    end
    drive(1'b0, 1'b1, '0, '0);
    idle(1);
    wait_drain();
    end_test("back to back");

    // write alone, outputs still show the last launched block
    random_block(br, bi);
    drive(1'b1, 1'b0, br, bi);
    idle(8);
    @(negedge clk);
    check_block("held", last_exp_real, last_exp_imag);
    end_test("write without start");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verif/fft8_asserts.sv ====
//////////////////////////////////////////////////
// concurrent checks on fft_ready timing and reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_asserts (
  input logic clk,
  input logic reset_n,
  input logic start_fft,
  input logic launch_valid,
  input logic fft_ready
);

  // ready rises on the third edge after the start edge,
  // so the sampled value shows up one edge later
  property ready_after_start;
    @(posedge clk) disable iff (!reset_n)
      fft_ready == $past(start_fft, 4);
  endproperty

  property quiet_in_reset;
    @(posedge clk) !reset_n |-> (!fft_ready && !launch_valid);
  endproperty

  // three stage registers between launch and ready
  property launch_to_ready;
    @(posedge clk) disable iff (!reset_n)
      launch_valid |-> ##3 fft_ready;
  endproperty

  a_ready_after_start: assert property (ready_after_start)
    else $error("fft_ready does not follow start_fft by three cycles");

  a_quiet_in_reset: assert property (quiet_in_reset)
    else $error("fft_ready or launch_valid high during reset");

  a_launch_to_ready: assert property (launch_to_ready)
    else $error("launch_valid not followed by fft_ready");

endmodule

// ==== src/fft8_top.sv ====
//////////////////////////////////////////////////
// 8-point FFT top, load stage and three
// registered butterfly stages
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_top
  import fft8_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        write,
  input  logic        start_fft,
  input  sample_vec_t in_real,
  input  sample_vec_t in_imag,
  output sample_vec_t out_real,
  output sample_vec_t out_imag,
  output logic        fft_ready
);

  sample_vec_t launch_real;
  sample_vec_t launch_imag;
  logic        launch_valid;
  sample_vec_t s0_real;
  sample_vec_t s0_imag;
  logic        s0_valid;
  sample_vec_t s1_real;
  sample_vec_t s1_imag;
  logic        s1_valid;

  fft8_load u_load (
    .clk          (clk),
    .reset_n      (reset_n),
    .write        (write),
    .start_fft    (start_fft),
    .in_real      (in_real),
    .in_imag      (in_imag),
    .launch_real  (launch_real),
    .launch_imag  (launch_imag),
    .launch_valid (launch_valid)
  );

  // 2-point DFTs on bit-reversed pairs
  fft8_stage #(.STAGE(0)) u_stage0 (
    .clk (clk), .reset_n (reset_n),
    .in_real (launch_real), .in_imag (launch_imag), .in_valid (launch_valid),
    .out_real (s0_real), .out_imag (s0_imag), .out_valid (s0_valid)
  );

  fft8_stage #(.STAGE(1)) u_stage1 (
    .clk (clk), .reset_n (reset_n),
    .in_real (s0_real), .in_imag (s0_imag), .in_valid (s0_valid),
    .out_real (s1_real), .out_imag (s1_imag), .out_valid (s1_valid)
  );

  // last stage register is the result register
  fft8_stage #(.STAGE(2)) u_stage2 (
    .clk (clk), .reset_n (reset_n),
    .in_real (s1_real), .in_imag (s1_imag), .in_valid (s1_valid),
    .out_real (out_real), .out_imag (out_imag), .out_valid (fft_ready)
  );

endmodule

// ==== src/fft8_stage.sv ====
//////////////////////////////////////////////////
// one FFT stage with four butterflies,
// the output register and the valid delay
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_stage
  import fft8_pkg::*;
#(
  parameter int STAGE = 0
)
(
  input  logic        clk,
  input  logic        reset_n,
  input  sample_vec_t in_real,
  input  sample_vec_t in_imag,
  input  logic        in_valid,
  output sample_vec_t out_real,
  output sample_vec_t out_imag,
  output logic        out_valid
);

  localparam int SPAN = STAGE_SPAN[STAGE];

  sample_vec_t bf_real;  // butterfly results before the register
  sample_vec_t bf_imag;

  //////////////////////////////////////////////////
  // slot routing
  //////////////////////////////////////////////////
  for (genvar k = 0; k < N_BFLY; k++)
  begin : g_bfly
    // stage 0 reads bit-reversed pairs and packs results in 2k, 2k+1;
    // later stages work in place inside groups of 2*SPAN
    localparam int A_IDX = (STAGE == 0) ? ((k % 2) * 2 + k / 2)
                                        : ((k / SPAN) * 2 * SPAN + k % SPAN);
    localparam int B_IDX = A_IDX + SPAN;
    localparam int O0_IDX = (STAGE == 0) ? 2 * k : A_IDX;
    localparam int O1_IDX = (STAGE == 0) ? 2 * k + 1 : B_IDX;

    fft8_butterfly u_bfly (
      .a_real  (in_real[A_IDX]),
      .a_imag  (in_imag[A_IDX]),
      .b_real  (in_real[B_IDX]),
      .b_imag  (in_imag[B_IDX]),
      .twiddle (STAGE_TWIDDLE[STAGE][k]),
      .x0_real (bf_real[O0_IDX]),
      .x0_imag (bf_imag[O0_IDX]),
      .x1_real (bf_real[O1_IDX]),
      .x1_imag (bf_imag[O1_IDX])
    );
  end

  //////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////
  // loads every edge, no enable
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      out_real  <= '0;
      out_imag  <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_real  <= bf_real;
      out_imag  <= bf_imag;
      out_valid <= in_valid;  // travels with its block
    end
  end

endmodule

// ==== src/fft8_butterfly.sv ====
//////////////////////////////////////////////////
// radix-2 butterfly with twiddle rotation
// and 0.707 shift-add scaling
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_butterfly
  import fft8_pkg::*;
(
  input  sample_t  a_real,
  input  sample_t  a_imag,
  input  sample_t  b_real,
  input  sample_t  b_imag,
  input  twiddle_t twiddle,
  output sample_t  x0_real,
  output sample_t  x0_imag,
  output sample_t  x1_real,
  output sample_t  x1_imag
);

  sample_t b_sum;        // br + bi
  sample_t b_diff;       // bi - br
  sample_t sum_scaled;
  sample_t diff_scaled;
  sample_t bw_real;      // rotated b
  sample_t bw_imag;

  // x * 0.707 as a wrapping sum of truncated arithmetic shifts
  function automatic sample_t scale_707(sample_t x);
    sample_t acc;
    acc = '0;
    for (int i = 0; i < N_SCALE; i++)
    begin
      acc = acc + (x >>> SCALE_SHIFTS[i]);
    end
    return acc;
  endfunction

  assign b_sum       = b_real + b_imag;
  assign b_diff      = b_imag - b_real;
  assign sum_scaled  = scale_707(b_sum);
  assign diff_scaled = scale_707(b_diff);

  //////////////////////////////////////////////////
  // twiddle select
  //////////////////////////////////////////////////
  always_comb
  begin
    case (twiddle)
      W0:
      begin
        bw_real = b_real;
        bw_imag = b_imag;
      end
      W1:
      begin
        bw_real = sum_scaled;
        bw_imag = diff_scaled;
      end
      W2:
      begin
        bw_real = b_imag;   // multiply by -j is a swap
        bw_imag = -b_real;
      end
      W3:
      begin
        bw_real = diff_scaled;
        bw_imag = -sum_scaled;
      end
    endcase
  end

  // sum and difference, wrapping
  assign x0_real = a_real + bw_real;
  assign x0_imag = a_imag + bw_imag;
  assign x1_real = a_real - bw_real;
  assign x1_imag = a_imag - bw_imag;

endmodule

// ==== src/fft8_load.sv ====
//////////////////////////////////////////////////
// input capture and launch registers
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fft8_load
  import fft8_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        write,
  input  logic        start_fft,
  input  sample_vec_t in_real,
  input  sample_vec_t in_imag,
  output sample_vec_t launch_real,
  output sample_vec_t launch_imag,
  output logic        launch_valid
);

  sample_vec_t hold_real;  // block captured by write
  sample_vec_t hold_imag;

  //////////////////////////////////////////////////
  // capture on write
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      hold_real <= '0;
      hold_imag <= '0;
    end
    else if (write)
    begin
      hold_real <= in_real;
      hold_imag <= in_imag;
    end
  end

  //////////////////////////////////////////////////
  // launch on start
  //////////////////////////////////////////////////
  // a write in the same cycle lands in hold one edge later,
  // so the launch still takes the older block
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      launch_real  <= '0;
      launch_imag  <= '0;
      launch_valid <= 1'b0;
    end
    else
    begin
      launch_valid <= start_fft;  // one cycle per start
      if (start_fft)
      begin
        launch_real <= hold_real;
        launch_imag <= hold_imag;
      end
    end
  end

endmodule

// ==== src/fft8_pkg.sv ====
//////////////////////////////////////////////////
// widths, sample and vector types, twiddle codes
// and per-stage butterfly pairing tables
//////////////////////////////////////////////////

package fft8_pkg;

  localparam int SAMPLE_W = 16;
  localparam int N_POINTS = 8;
  localparam int N_STAGES = 3;
  localparam int N_BFLY   = N_POINTS / 2;  // butterflies per stage
  localparam int N_SCALE  = 6;

  // one real or imaginary word, wraps mod 2^16
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // slot 0 sits in the low bits
  typedef sample_t [N_POINTS-1:0] sample_vec_t;

  // rotation applied to the B input of a butterfly
  typedef enum logic [1:0] {
    W0 = 2'd0,  // x 1
    W1 = 2'd1,  // x e^-j*pi/4
    W2 = 2'd2,  // x -j
    W3 = 2'd3   // x e^-j*3pi/4
  } twiddle_t;

  //////////////////////////////////////////////////
  // stage tables
  //////////////////////////////////////////////////

  // partner distance of a butterfly in slot terms
  // stage 0 reads bit-reversed pairs 4 apart, stage 1 works inside
  // groups of four, and stage 2 joins slot k with k+4 so that the
  // results land in natural order X0..X7
  localparam int STAGE_SPAN [N_STAGES] = '{4, 2, 4};

  // twiddle per butterfly, butterfly 0 first
  localparam twiddle_t STAGE_TWIDDLE [N_STAGES][N_BFLY] = '{
    '{W0, W0, W0, W0},
    '{W0, W2, W0, W2},
    '{W0, W1, W2, W3}
  };

  // 0.707 ~ 2^-1 + 2^-3 + 2^-4 + 2^-6 + 2^-8 + 2^-10
  localparam int SCALE_SHIFTS [N_SCALE] = '{1, 3, 4, 6, 8, 10};

endpackage
